// File: hdl/dot_defs.svh
`ifndef DOT_DEFS_SVH
`define DOT_DEFS_SVH

// Lanes per 64-bit word and width of one lane
`define DOT_LANES 8
`define DOT_LANE_W 8

// Beat sum of eight int8 products, with headroom
`define DOT_SUM_W 25

// Window accumulator
`define DOT_ACC_W 32

// Weight words held, and so the longest window in beats
`define DOT_DEPTH 8

`endif

// File: hdl/mac_pkg.sv
`include "dot_defs.svh"

package mac_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath arithmetic types
    ////////////////////////////////////////////////////////////////////////////

    // One signed int8 activation or weight
    typedef logic signed [`DOT_LANE_W-1:0] lane_t;

    // Full data or weight word, lane 0 in the low byte
    typedef lane_t [`DOT_LANES-1:0] lane_vec_t;

    // Full-precision product of two lanes
    typedef logic signed [2*`DOT_LANE_W-1:0] prod_t;

    // Sum of all lane products of one beat
    typedef logic signed [`DOT_SUM_W-1:0] sum_t;

    // Running window total
    typedef logic signed [`DOT_ACC_W-1:0] acc_t;

endpackage

// File: hdl/host_pkg.sv
package host_pkg;

    import mac_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Host-side word layouts
    ////////////////////////////////////////////////////////////////////////////

    // Window configuration, written at address 0
    typedef struct packed {
        logic [54:0] reserved;
        logic        relu_en;
        logic [4:0]  shift;
        logic [2:0]  beats_m1;
    } win_cfg_t;

    // Host write data, read as weights or as configuration
    // depending on the address it goes to
    typedef union packed {
        lane_vec_t lanes;
        win_cfg_t  cfg;
    } host_word_u;

endpackage

// File: hdl/psum_if.sv
`timescale 1ns/1ps

`include "dot_defs.svh"

// Beat sums from the multiplier stage to the accumulator
interface psum_if #(
    parameter int W = `DOT_SUM_W
);

    logic                valid;
    logic signed [W-1:0] sum;
    // Window boundary markers, qualified by valid
    logic                first;
    logic                last;

    modport src (
        output valid,
        output sum,
        output first,
        output last
    );

    modport dst (
        input valid,
        input sum,
        input first,
        input last
    );

endinterface

// File: hdl/window_ctrl.sv
`timescale 1ns/1ps

`include "dot_defs.svh"

module window_ctrl
    import mac_pkg::*;
    import host_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           host_wr,
    input  logic [3:0]                     host_addr,
    input  host_word_u                     host_wdata,
    input  logic                           data_valid,
    output logic                           wb_we,
    output logic [$clog2(`DOT_DEPTH)-1:0]  wb_waddr,
    output lane_vec_t                      wb_wdata,
    output logic [$clog2(`DOT_DEPTH)-1:0]  beat_idx,
    output logic                           en,
    output logic                           first,
    output logic                           last,
    output logic [4:0]                     shift,
    output logic                           relu_en
);

    win_cfg_t                          cfg;
    logic [$clog2(`DOT_DEPTH)-1:0]     beat_cnt;
    logic                              cfg_we;

    ////////////////////////////////////////////////////////////////////////////
    // Host write decode
    ////////////////////////////////////////////////////////////////////////////

    assign cfg_we = host_wr && (host_addr == 4'd0);

    // Addresses 1..DOT_DEPTH hit the weight bank
    assign wb_we    = host_wr && (host_addr != 4'd0) && (host_addr <= 4'(`DOT_DEPTH));
    // Low bits minus one, address 8 wraps to word 7
    assign wb_waddr = host_addr[$clog2(`DOT_DEPTH)-1:0] - 1'b1;
    assign wb_wdata = host_wdata.lanes;

    ////////////////////////////////////////////////////////////////////////////
    // Configuration and beat counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // Default is a single-beat window, no shift, no ReLU
            cfg      <= '0;
            beat_cnt <= '0;
        end
        else if (cfg_we)
        begin
            // New config restarts the window
            cfg      <= host_wdata.cfg;
            beat_cnt <= '0;
        end
        else if (data_valid)
        begin
            if (last)
            begin
                beat_cnt <= '0;
            end
            else
            begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Window markers from the count
    assign first = (beat_cnt == '0);
    assign last  = (beat_cnt == cfg.beats_m1);

    assign beat_idx = beat_cnt;
    assign en       = data_valid;

    // Requantizer settings
    assign shift   = cfg.shift;
    assign relu_en = cfg.relu_en;

endmodule

// File: hdl/weight_bank.sv
`timescale 1ns/1ps

`include "dot_defs.svh"

module weight_bank
    import mac_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           we,
    input  logic [$clog2(`DOT_DEPTH)-1:0]  waddr,
    input  lane_vec_t                      wdata,
    input  logic [$clog2(`DOT_DEPTH)-1:0]  raddr,
    output lane_vec_t                      weight
);

    // One weight word per beat position
    lane_vec_t bank [`DOT_DEPTH];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `DOT_DEPTH; i++)
            begin
                bank[i] <= '0;
            end
        end
        else if (we)
        begin
            bank[waddr] <= wdata;
        end
    end

    // Asynchronous read so the word lines up with the current beat
    assign weight = bank[raddr];

endmodule

// File: hdl/mult_sum.sv
`timescale 1ns/1ps

`include "dot_defs.svh"

module mult_sum
    import mac_pkg::*;
#(
    parameter int gen_width = `DOT_SUM_W
)(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       first,
    input  logic       last,
    input  lane_vec_t  weight,
    input  lane_vec_t  data,
    psum_if.src        ps
);

    prod_t                       prod [`DOT_LANES];
    logic                        valid_q;
    logic                        first_q;
    logic                        last_q;

    // Adder tree levels
    logic signed [gen_width-1:0] lvl1 [4];
    logic signed [gen_width-1:0] lvl2 [2];
    logic signed [gen_width-1:0] total;

    ////////////////////////////////////////////////////////////////////////////
    // Lane multipliers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `DOT_LANES; i++)
            begin
                prod[i] <= '0;
            end
            valid_q <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
        end
        else
        begin
            for (int i = 0; i < `DOT_LANES; i++)
            begin
                // Idle cycles leave zero products behind
                if (en)
                begin
                    prod[i] <= $signed(weight[i]) * $signed(data[i]);
                end
                else
                begin
                    prod[i] <= '0;
                end
            end
            valid_q <= en;
            first_q <= first;
            last_q  <= last;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Balanced adder tree
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            lvl1[i] = gen_width'(prod[2*i]) + gen_width'(prod[2*i+1]);
        end
        for (int i = 0; i < 2; i++)
        begin
            lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
        end
        total = lvl2[0] + lvl2[1];
    end

    assign ps.valid = valid_q;
    assign ps.sum   = total;
    assign ps.first = first_q;
    assign ps.last  = last_q;

endmodule

// File: hdl/psum_accum.sv
`timescale 1ns/1ps

`include "dot_defs.svh"

module psum_accum
    import mac_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    psum_if.dst   ps,
    output logic  acc_valid,
    output acc_t  acc_total
);

    sum_t beat_sum;
    acc_t running;
    acc_t next_sum;

    assign beat_sum = ps.sum;

    // First beat starts a fresh total
    always_comb
    begin
        if (ps.first)
        begin
            next_sum = acc_t'(beat_sum);
        end
        else
        begin
            next_sum = running + acc_t'(beat_sum);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Running sum and window total
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (ps.valid)
        begin
            running <= next_sum;
            if (ps.last)
            begin
                acc_total <= next_sum;
            end
        end
    end

    // One-cycle strobe per completed window
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            acc_valid <= 1'b0;
        end
        else
        begin
            acc_valid <= ps.valid && ps.last;
        end
    end

endmodule

// File: hdl/requant_relu.sv
`timescale 1ns/1ps

`include "dot_defs.svh"

module requant_relu
    import mac_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        acc_valid,
    input  acc_t        acc_total,
    input  logic [4:0]  shift,
    input  logic        relu_en,
    output logic        out_valid,
    output lane_t       out_data
);

    localparam acc_t SAT_MAX = 127;
    localparam acc_t SAT_MIN = -128;

    acc_t  shifted;
    acc_t  rect;
    lane_t sat;

    always_comb
    begin
        // Arithmetic shift, truncates toward minus infinity
        shifted = acc_total >>> shift;

        if (relu_en && shifted[`DOT_ACC_W-1])
        begin
            rect = '0;
        end
        else
        begin
            rect = shifted;
        end

        // Clamp to int8
        if (rect > SAT_MAX)
        begin
            sat = 8'sd127;
        end
        else if (rect < SAT_MIN)
        begin
            sat = -8'sd128;
        end
        else
        begin
            sat = rect[`DOT_LANE_W-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (acc_valid)
        begin
            out_data <= sat;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= acc_valid;
        end
    end

endmodule

// File: hdl/dot_engine_top.sv
`timescale 1ns/1ps

`include "dot_defs.svh"

module dot_engine_top
    import mac_pkg::*;
    import host_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        host_wr,
    input  logic [3:0]  host_addr,
    input  host_word_u  host_wdata,
    input  logic        data_valid,
    input  lane_vec_t   data,
    output logic        out_valid,
    output lane_t       out_data
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////////////////////////////////////////

    logic                           wb_we;
    logic [$clog2(`DOT_DEPTH)-1:0]  wb_waddr;
    lane_vec_t                      wb_wdata;
    logic [$clog2(`DOT_DEPTH)-1:0]  beat_idx;
    lane_vec_t                      weight;
    logic                           en;
    logic                           first;
    logic                           last;
    logic [4:0]                     shift;
    logic                           relu_en;
    logic                           acc_valid;
    acc_t                           acc_total;

    psum_if #(.W(`DOT_SUM_W)) psum ();

    window_ctrl i_window_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_wr    (host_wr),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .data_valid (data_valid),
        .wb_we      (wb_we),
        .wb_waddr   (wb_waddr),
        .wb_wdata   (wb_wdata),
        .beat_idx   (beat_idx),
        .en         (en),
        .first      (first),
        .last       (last),
        .shift      (shift),
        .relu_en    (relu_en)
    );

    weight_bank i_weight_bank (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (wb_we),
        .waddr  (wb_waddr),
        .wdata  (wb_wdata),
        .raddr  (beat_idx),
        .weight (weight)
    );

    // Three register stages from beat to output strobe
    mult_sum #(.gen_width(`DOT_SUM_W)) i_mult_sum (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en),
        .first  (first),
        .last   (last),
        .weight (weight),
        .data   (data),
        .ps     (psum.src)
    );

    psum_accum i_psum_accum (
        .clk       (clk),
        .rst_n     (rst_n),
        .ps        (psum.dst),
        .acc_valid (acc_valid),
        .acc_total (acc_total)
    );

    requant_relu i_requant_relu (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_valid (acc_valid),
        .acc_total (acc_total),
        .shift     (shift),
        .relu_en   (relu_en),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// File: test/dot_engine_tb.sv
`timescale 1ns/1ps

`include "dot_defs.svh"

module dot_engine_tb
    import mac_pkg::*;
();

    // Drive edge of a window's last beat to the negedge where out_valid is seen
    localparam int LATENCY_NS    = 70;
    localparam int DRAIN_TIMEOUT = 200;

    logic        clk;
    logic        rst_n;
    logic        host_wr;
    logic [3:0]  host_addr;
    logic [63:0] host_wdata;
    logic        data_valid;
    lane_vec_t   data;
    logic        out_valid;
    lane_t       out_data;

    // Shadow of the DUT state and of the window being sent
    logic [63:0] sh_w [`DOT_DEPTH];
    logic [63:0] win_data [`DOT_DEPTH];
    int          sh_beats;
    int          sh_shift;
    bit          sh_relu;
    int          beat_pos;

    int          exp_q [$];
    string       name_q [$];
    time         due_q [$];
    string       test_name;
    int          value_errs;
    int          other_errs;

    dot_engine_top i_dot_engine_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_wr    (host_wr),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .data_valid (data_valid),
        .data       (data),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

    always
    begin
        #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic int window_result(int n, int sh, bit relu);
        longint acc;
        longint v;
        acc = 0;
        for (int b = 0; b < n; b++)
        begin
            for (int l = 0; l < `DOT_LANES; l++)
            begin
                acc += longint'($signed(sh_w[b][8*l +: 8]))
                     * longint'($signed(win_data[b][8*l +: 8]));
            end
        end
        // Floors toward minus infinity
        v = acc >>> sh;
        if (relu && v < 0)
        begin
            v = 0;
        end
        if (v > 127)
        begin
            v = 127;
        end
        else if (v < -128)
        begin
            v = -128;
        end
        return int'(v);
    endfunction

    function automatic logic [63:0] rand_word();
        return {$urandom(), $urandom()};
    endfunction

    // Lanes in -4..3
    function automatic logic [63:0] small_word();
        logic [63:0] w;
        for (int l = 0; l < `DOT_LANES; l++)
        begin
            w[8*l +: 8] = 8'($urandom_range(0, 7)) - 8'd4;
        end
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_drain();
        for (int i = 0; i < DRAIN_TIMEOUT; i++)
        begin
            @(posedge clk);
            data_valid <= 1'b0;
            if (exp_q.size() == 0)
            begin
                break;
            end
        end
        if (exp_q.size() != 0)
        begin
            $display("Timeout waiting for %0d pending outputs in %s", exp_q.size(), test_name);
            $display("Errors: %0d value, %0d other", value_errs, other_errs + 1);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    endtask

    task automatic host_write(input logic [3:0] addr, input logic [63:0] word);
        @(posedge clk);
        host_wr    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= word;
        @(posedge clk);
        host_wr <= 1'b0;
        if (addr >= 1 && addr <= `DOT_DEPTH)
        begin
            sh_w[addr - 1] = word;
        end
    endtask

    task automatic set_config(int beats, int sh, bit relu);
        logic [54:0] rsv;
        // Junk in the reserved bits that the DUT ignores
        rsv = 55'({$urandom(), $urandom()});
        wait_drain();
        host_write(4'd0, {rsv, relu, 5'(sh), 3'(beats - 1)});
        sh_beats = beats;
        sh_shift = sh;
        sh_relu  = relu;
        beat_pos = 0;
    endtask

    task automatic send_beat(input logic [63:0] word);
        @(posedge clk);
        data_valid <= 1'b1;
        data       <= word;
        win_data[beat_pos] = word;
        beat_pos++;
        if (beat_pos == sh_beats)
        begin
            exp_q.push_back(window_result(sh_beats, sh_shift, sh_relu));
            name_q.push_back(test_name);
            due_q.push_back($time + LATENCY_NS);
            beat_pos = 0;
        end
    endtask

    task automatic idle(int n);
        for (int i = 0; i < n; i++)
        begin
            @(posedge clk);
            data_valid <= 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checker
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        int     exp_v;
        integer got;
        string  nm;
        time    due;
        if (!rst_n)
        begin
            assert (out_valid === 1'b0)
            else
            begin
                $display("out_valid was high during reset at %0t", $time);
                other_errs++;
            end
        end
        else if (out_valid === 1'b1)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                $display("out_valid pulsed at %0t with no window pending", $time);
                other_errs++;
            end
            if (exp_q.size() != 0)
            begin
                exp_v = exp_q.pop_front();
                nm    = name_q.pop_front();
                due   = due_q.pop_front();
                got   = out_data;
                assert (got == exp_v)
                else
                begin
                    $display("ERR %s expected %0d actual %0d", nm, exp_v, got);
                    value_errs++;
                end
                assert ($time == due)
                else
                begin
                    $display("Output of %s came at %0t instead of %0t", nm, $time, due);
                    other_errs++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        void'($urandom(51));
        clk        = 1'b0;
        rst_n      = 1'b0;
        host_wr    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        data_valid = 1'b0;
        data       = '0;
        value_errs = 0;
        other_errs = 0;
        sh_beats   = 1;
        sh_shift   = 0;
        sh_relu    = 0;
        beat_pos   = 0;
        for (int i = 0; i < `DOT_DEPTH; i++)
        begin
            sh_w[i]     = '0;
            win_data[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // Default config and zero weights give 0
        test_name = "reset_default";
        send_beat(rand_word());
        wait_drain();

        // Back-to-back single-beat windows
        test_name = "single_beat";
        set_config(1, 0, 0);
        host_write(4'd1, 64'h80_7f_01_ff_02_fe_40_c0);
        host_write(4'd9, rand_word());
        send_beat(64'h80_80_80_80_80_80_80_80);
        send_beat(64'h7f_7f_7f_7f_7f_7f_7f_7f);
        send_beat(64'h01_ff_80_7f_03_fd_00_10);
        for (int k = 0; k < 12; k++)
        begin
            send_beat(small_word());
        end
        wait_drain();

        // Full-depth windows with several in flight
        test_name = "eight_beat";
        set_config(8, 11, 0);
        for (int w = 0; w < `DOT_DEPTH; w++)
        begin
            host_write(4'(w + 1), rand_word());
        end
        for (int k = 0; k < 4 * 8; k++)
        begin
            send_beat(rand_word());
        end
        wait_drain();

        // Clamping at both ends and then with ReLU
        test_name = "saturate";
        set_config(2, 0, 0);
        host_write(4'd1, {8{8'h7f}});
        host_write(4'd2, {8{8'h80}});
        send_beat({8{8'h7f}});
        send_beat({8{8'h7f}});
        send_beat({8{8'h7f}});
        send_beat({8{8'h80}});
        send_beat({8{8'h80}});
        send_beat({8{8'h7f}});
        test_name = "relu_saturate";
        set_config(2, 0, 1);
        send_beat({8{8'h7f}});
        send_beat({8{8'h7f}});
        send_beat({8{8'h7f}});
        send_beat({8{8'h80}});
        test_name = "shift";
        set_config(2, 5, 0);
        for (int k = 0; k < 12; k++)
        begin
            send_beat(rand_word());
        end
        test_name = "shift_relu";
        set_config(2, 9, 1);
        for (int k = 0; k < 12; k++)
        begin
            send_beat(rand_word());
        end

        // Random configs with gaps inside windows
        test_name = "random";
        for (int r = 0; r < 6; r++)
        begin
            set_config($urandom_range(1, 8), $urandom_range(0, 15), $urandom_range(0, 1));
            for (int w = 0; w < `DOT_DEPTH; w++)
            begin
                host_write(4'(w + 1), rand_word());
            end
            for (int k = 0; k < 5 * sh_beats; k++)
            begin
                if ($urandom_range(0, 3) == 0)
                begin
                    idle($urandom_range(1, 3));
                end
                send_beat(rand_word());
            end
        end
        wait_drain();
        idle(10);

        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hdl
hdl/mac_pkg.sv
hdl/host_pkg.sv
hdl/psum_if.sv
hdl/window_ctrl.sv
hdl/weight_bank.sv
hdl/mult_sum.sv
hdl/psum_accum.sv
hdl/requant_relu.sv
hdl/dot_engine_top.sv
test/dot_engine_tb.sv
